// File: echo_sender.sv
// turns echo requests into a valid/ready byte stream, banner included
`timescale 1ns/1ps

module echo_sender import matrix_entry_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       req_valid,
  input  echo_kind_t req_kind,
  input  logic [7:0] req_value,
  input  logic       tx_ready,
  output logic       req_ready,
  output logic       done,
  output logic [7:0] tx_data,
  output logic       tx_valid
);
  localparam int IDX_W = idx_w(BANNER_LEN);

  typedef enum logic {
    S_IDLE,
    S_SEND
  } state_t;

  state_t           state;
  echo_kind_t       kind_q;
  logic [7:0]       value_q;
  logic [IDX_W-1:0] idx;
  logic [IDX_W-1:0] last_idx;
  logic             take;

  assign req_ready = (state == S_IDLE);
  assign tx_valid  = (state == S_SEND);
  assign take      = tx_valid && tx_ready;

  // bytes per request, minus one
  always_comb begin
    case (kind_q)
      ECHO_BANNER:    last_idx = IDX_W'(BANNER_LEN - 1);
      ECHO_CELL_LAST: last_idx = IDX_W'(1);
      default:        last_idx = '0;
    endcase
  end

  always_comb begin
    case (kind_q)
      ECHO_BANNER:    tx_data = BANNER_BYTES[idx];
      ECHO_ID:        tx_data = ID_TAG | value_q;
      ECHO_CELL:      tx_data = value_q;
      ECHO_CELL_LAST: tx_data = (idx == '0) ? value_q : NEWLINE_BYTE;
      default:        tx_data = NEWLINE_BYTE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= S_IDLE;
      kind_q <= ECHO_NEWLINE;
      idx    <= '0;
      done   <= 1'b0;
    end else begin
      done <= 1'b0;
      if (state == S_IDLE && req_valid) begin
        state  <= S_SEND;
        kind_q <= req_kind;
        idx    <= '0;
      end else if (take) begin
        if (idx == last_idx) begin
          state <= S_IDLE;
          done  <= 1'b1;
        end else begin
          idx <= idx + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_IDLE && req_valid) value_q <= req_value;
  end

  a_tx_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (tx_valid && !tx_ready) |=> (tx_valid && $stable(tx_data)));

endmodule

// File: matrix_entry.f
matrix_entry_pkg.sv
matrix_if.sv
matrix_input.sv
matrix_store.sv
echo_sender.sv
matrix_entry_top.sv
matrix_entry_tb.sv

// File: matrix_entry_pkg.sv
// shared element type, echo request kinds and banner constants for the matrix entry design
package matrix_entry_pkg;

  // one stored matrix element, taken straight from one rx byte
  typedef logic signed [7:0] elem_t;

  // kinds of request the controller hands to the echo sender
  typedef enum logic [2:0] {
    ECHO_BANNER,
    ECHO_ID,
    ECHO_CELL,
    ECHO_CELL_LAST,
    ECHO_NEWLINE
  } echo_kind_t;

  // banner sent once when input mode starts
  localparam int BANNER_LEN = 4;
  localparam logic [7:0] BANNER_BYTES [BANNER_LEN] = '{8'h49, 8'h4E, 8'h50, 8'h0A};

  localparam logic [7:0] NEWLINE_BYTE = 8'h0A;

  // ORed with the slot number to form the echo header byte
  localparam logic [7:0] ID_TAG = 8'h80;

  // index width for n entries, at least one bit
  function automatic int idx_w(input int n);
    return (n > 1) ? $clog2(n) : 1;
  endfunction

  // width that holds a dimension count from 0 up to the larger limit
  function automatic int dim_w(input int rows, input int cols);
    return $clog2(((rows > cols) ? rows : cols) + 1);
  endfunction

endpackage

// File: matrix_entry_tb.sv
// self-checking testbench for matrix_entry_top, run as the simulation top through run.sh
`timescale 1ns/1ps

module matrix_entry_tb import matrix_entry_pkg::*; ();
  localparam int MAX_ROWS    = 4;
  localparam int MAX_COLS    = 4;
  localparam int NUM_SLOTS   = 4;
  localparam int PAD_TIMEOUT = 64;
  localparam int ERR_HOLD    = 40;
  localparam int ADR_W       = 7;
  localparam int CELLS       = MAX_ROWS * MAX_COLS;
  localparam int WAIT_LIMIT  = 3000;
  localparam elem_t VAL_MIN  = -8'sd20;
  localparam elem_t VAL_MAX  = 8'sd50;
  // dimensions of the five matrices in the slot test
  localparam int SEQ_ROWS [5] = '{1, 2, 4, 3, 2};
  localparam int SEQ_COLS [5] = '{1, 3, 4, 2, 4};

  logic             clk;
  logic             rst_n;
  logic             start;
  logic             exit;
  logic [7:0]       rx_data;
  logic             rx_valid;
  elem_t            val_min;
  elem_t            val_max;
  logic             tx_ready;
  logic [7:0]       tx_data;
  logic             tx_valid;
  logic             err;
  logic             done;
  logic             wb_cyc;
  logic             wb_stb;
  logic             wb_we;
  logic [ADR_W-1:0] wb_adr;
  logic [7:0]       wb_dat_o;
  logic             wb_ack;

  logic [7:0] exp_q [$];
  logic [7:0] want_byte;
  logic [7:0] cur  [CELLS];
  logic [7:0] keep [CELLS];
  int         errors;
  int         err_mark;
  int         tests_run;
  int         tests_failed;
  string      test_name;
  // slot allocation model
  int         next_slot;
  int         last_slot;
  int         last_rows;
  int         last_cols;
  bit         any_slot;

  matrix_entry_top #(
    .MAX_ROWS   (MAX_ROWS),
    .MAX_COLS   (MAX_COLS),
    .NUM_SLOTS  (NUM_SLOTS),
    .PAD_TIMEOUT(PAD_TIMEOUT),
    .ERR_HOLD   (ERR_HOLD)
  ) dut_i (
    .clk, .rst_n, .start, .exit, .rx_data, .rx_valid, .val_min, .val_max, .tx_ready,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .tx_data, .tx_valid, .err, .done, .wb_dat_o, .wb_ack
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // every accepted tx byte is matched against the front of the expected stream
  always @(posedge clk) begin
    if (rst_n && tx_valid && tx_ready) begin
      assert (exp_q.size() > 0) else begin
        $display("unexpected tx byte %h while no echo was expected", tx_data);
        errors++;
      end
      if (exp_q.size() > 0) begin
        want_byte = exp_q.pop_front();
        assert (tx_data == want_byte) else begin
          $display("FAIL tx_data got %h expected %h", tx_data, want_byte);
          errors++;
        end
      end
    end
  end

  // stimulus lands on the falling edge, tx_ready is redrawn each time
  task automatic next_cycle();
    @(negedge clk);
    tx_ready = ($urandom_range(3) != 0);
  endtask

  task automatic idle(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic note_timeout(input string what);
    $display("timeout while waiting for %s", what);
    errors++;
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    err_mark  = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors == err_mark) begin
      $display("test %0d %s: ok", tests_run, test_name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, test_name, errors - err_mark);
    end
  endtask

  // expected cell: listed elements in row-major order, zero past the list
  function automatic logic [7:0] cell_value(input logic [7:0] vals [CELLS],
                                            input int n_given, input int idx);
    return (idx < n_given) ? vals[idx] : 8'h00;
  endfunction

  function automatic void expected_banner();
    for (int i = 0; i < BANNER_LEN; i++) begin
      exp_q.push_back(BANNER_BYTES[i]);
    end
  endfunction

  // reference echo of one matrix: tagged id, rows ended by newline, trailing newline
  function automatic void expected_echo(input int slot, input int rows, input int cols,
                                        input int n_given, input logic [7:0] vals [CELLS]);
    exp_q.push_back(ID_TAG | 8'(slot));
    for (int r = 0; r < rows; r++) begin
      for (int c = 0; c < cols; c++) begin
        exp_q.push_back(cell_value(vals, n_given, r * cols + c));
      end
      exp_q.push_back(NEWLINE_BYTE);
    end
    exp_q.push_back(NEWLINE_BYTE);
  endfunction

  function automatic int model_alloc(input int rows, input int cols);
    int slot;
    slot      = next_slot;
    next_slot = (next_slot + 1) % NUM_SLOTS;
    last_slot = slot;
    last_rows = rows;
    last_cols = cols;
    any_slot  = 1'b1;
    return slot;
  endfunction

  function automatic logic [7:0] status_value();
    return (any_slot ? 8'h80 : 8'h00) | 8'(last_slot);
  endfunction

  // cell address: top bit set, then 2-bit slot, row and col fields
  function automatic int cell_addr(input int slot, input int row, input int col);
    return (1 << (ADR_W - 1)) | (slot << 4) | (row << 2) | col;
  endfunction

  task automatic fill_random();
    for (int i = 0; i < CELLS; i++) begin
      cur[i] = 8'(int'($urandom_range(int'(VAL_MAX) - int'(VAL_MIN))) + int'(VAL_MIN));
    end
  endtask

  task automatic send_byte(input logic [7:0] b);
    next_cycle();
    rx_data  = b;
    rx_valid = 1'b1;
    next_cycle();
    rx_valid = 1'b0;
  endtask

  task automatic send_matrix(input int rows, input int cols, input int n_given);
    idle(2);
    send_byte(8'(rows));
    send_byte(8'(cols));
    for (int i = 0; i < n_given; i++) begin
      idle(2);
      send_byte(cur[i]);
    end
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < WAIT_LIMIT) begin
      n++;
      next_cycle();
    end
    if (exp_q.size() != 0) begin
      note_timeout("the expected tx bytes");
      exp_q.delete();
    end
  endtask

  task automatic wait_banner_start();
    int n;
    n = 0;
    while (!tx_valid && n < 3) begin
      n++;
      next_cycle();
    end
    assert (tx_valid) else begin
      $display("banner did not start within 3 cycles of start");
      errors++;
    end
  endtask

  // called on the falling edge right after the bad byte was taken
  task automatic expect_err();
    int n;
    n = 0;
    assert (err) else begin
      $display("err did not rise the cycle after the bad byte");
      errors++;
    end
    while (err && n <= ERR_HOLD + 10) begin
      n++;
      next_cycle();
    end
    if (err) note_timeout("err to fall");
    assert (n == ERR_HOLD) else begin
      $display("FAIL err hold cycles got %h expected %h", n, ERR_HOLD);
      errors++;
    end
  endtask

  task automatic wb_read(input int adr, output logic [7:0] data);
    int n;
    logic got_ack;
    next_cycle();
    wb_adr = ADR_W'(adr);
    wb_we  = 1'b0;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    n = 0;
    next_cycle();
    while (!wb_ack && n < 16) begin
      n++;
      next_cycle();
    end
    got_ack = wb_ack;
    data    = wb_dat_o;
    wb_cyc  = 1'b0;
    wb_stb  = 1'b0;
    if (!got_ack) note_timeout("wb_ack");
  endtask

  task automatic check_reg(input int adr, input logic [7:0] want, input string what);
    logic [7:0] got;
    wb_read(adr, got);
    assert (got == want) else begin
      $display("FAIL wb_dat_o %s got %h expected %h", what, got, want);
      errors++;
    end
  endtask

  task automatic check_cells(input int slot, input int rows, input int cols,
                             input int n_given, input logic [7:0] vals [CELLS]);
    logic [7:0] got;
    logic [7:0] want;
    for (int r = 0; r < rows; r++) begin
      for (int c = 0; c < cols; c++) begin
        wb_read(cell_addr(slot, r, c), got);
        want = cell_value(vals, n_given, r * cols + c);
        assert (got == want) else begin
          $display("FAIL wb_dat_o slot %0d cell %0d,%0d got %h expected %h",
                   slot, r, c, got, want);
          errors++;
        end
      end
    end
  endtask

  initial begin
    int slot;
    int pulses;
    void'($urandom(24264));
    rst_n    = 1'b0;
    start    = 1'b0;
    exit     = 1'b0;
    rx_data  = 8'h00;
    rx_valid = 1'b0;
    val_min  = VAL_MIN;
    val_max  = VAL_MAX;
    tx_ready = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    next_slot    = 0;
    last_slot    = 0;
    last_rows    = 0;
    last_cols    = 0;
    any_slot     = 1'b0;
    idle(3);
    rst_n = 1'b1;

    begin_test("full 3x4 entry");
    assert (!tx_valid && !err && !done && !wb_ack) else begin
      $display("outputs not idle after reset");
      errors++;
    end
    check_reg(0, 8'h00, "status");
    expected_banner();
    next_cycle();
    start = 1'b1;
    wait_banner_start();
    wait_drained();
    fill_random();
    slot = model_alloc(3, 4);
    expected_echo(slot, 3, 4, 12, cur);
    send_matrix(3, 4, 12);
    wait_drained();
    check_cells(slot, 3, 4, 12, cur);
    check_reg(1, 8'h34, "dims");
    end_test();

    begin_test("pad timeout");
    fill_random();
    slot = model_alloc(2, 3);
    expected_echo(slot, 2, 3, 2, cur);
    send_matrix(2, 3, 2);
    wait_drained();
    check_cells(slot, 2, 3, 2, cur);
    end_test();

    begin_test("element below val_min");
    fill_random();
    // the rejected matrix still claims its slot
    slot = model_alloc(2, 2);
    idle(2);
    send_byte(8'd2);
    send_byte(8'd2);
    idle(2);
    send_byte(cur[0]);
    idle(2);
    send_byte(8'(int'(VAL_MIN) - 1));
    expect_err();
    fill_random();
    slot = model_alloc(2, 2);
    expected_echo(slot, 2, 2, 4, cur);
    send_matrix(2, 2, 4);
    wait_drained();
    check_cells(slot, 2, 2, 4, cur);
    end_test();

    begin_test("bad dimensions");
    idle(2);
    send_byte(8'd0);
    expect_err();
    idle(2);
    send_byte(8'd2);
    send_byte(8'(MAX_COLS + 1));
    expect_err();
    check_reg(0, status_value(), "status");
    end_test();

    begin_test("round-robin slots");
    for (int m = 0; m < 5; m++) begin
      fill_random();
      slot = model_alloc(SEQ_ROWS[m], SEQ_COLS[m]);
      if (m == 1) keep = cur;
      expected_echo(slot, SEQ_ROWS[m], SEQ_COLS[m], SEQ_ROWS[m] * SEQ_COLS[m], cur);
      send_matrix(SEQ_ROWS[m], SEQ_COLS[m], SEQ_ROWS[m] * SEQ_COLS[m]);
      wait_drained();
    end
    check_reg(0, 8'h80, "status");
    check_reg(1, 8'((last_rows << 4) | last_cols), "dims");
    check_cells(1, SEQ_ROWS[1], SEQ_COLS[1], SEQ_ROWS[1] * SEQ_COLS[1], keep);
    end_test();

    begin_test("exit and restart");
    idle(2);
    exit = 1'b1;
    next_cycle();
    exit = 1'b0;
    pulses = 0;
    repeat (4) begin
      if (done) pulses++;
      next_cycle();
    end
    assert (pulses == 1) else begin
      $display("FAIL done pulses got %h expected %h", pulses, 1);
      errors++;
    end
    start = 1'b0;
    idle(2);
    expected_banner();
    start = 1'b1;
    wait_banner_start();
    wait_drained();
    end_test();

    // stray bytes after the last echo would show up here
    idle(20);
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: matrix_entry_top.sv
// top level: sets the matrix limits and wires controller, store and echo sender to the pins
`timescale 1ns/1ps

module matrix_entry_top import matrix_entry_pkg::*; #(
  parameter int MAX_ROWS    = 4,
  parameter int MAX_COLS    = 4,
  parameter int NUM_SLOTS   = 4,
  parameter int PAD_TIMEOUT = 1000,
  parameter int ERR_HOLD    = 200,
  localparam int ADR_W      = 1 + idx_w(NUM_SLOTS) + idx_w(MAX_ROWS) + idx_w(MAX_COLS)
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             start,
  input  logic             exit,
  input  logic [7:0]       rx_data,
  input  logic             rx_valid,
  input  elem_t            val_min,
  input  elem_t            val_max,
  input  logic             tx_ready,
  input  logic             wb_cyc,
  input  logic             wb_stb,
  input  logic             wb_we,
  input  logic [ADR_W-1:0] wb_adr,
  output logic [7:0]       tx_data,
  output logic             tx_valid,
  output logic             err,
  output logic             done,
  output logic [7:0]       wb_dat_o,
  output logic             wb_ack
);
  logic       req_valid;
  logic       req_ready;
  echo_kind_t req_kind;
  logic [7:0] req_value;
  logic       echo_done;

  matrix_wr_if #(.MAX_ROWS(MAX_ROWS), .MAX_COLS(MAX_COLS), .NUM_SLOTS(NUM_SLOTS)) wr_if ();
  matrix_rd_if #(.MAX_ROWS(MAX_ROWS), .MAX_COLS(MAX_COLS), .NUM_SLOTS(NUM_SLOTS)) rd_if ();

  matrix_input #(
    .MAX_ROWS   (MAX_ROWS),
    .MAX_COLS   (MAX_COLS),
    .NUM_SLOTS  (NUM_SLOTS),
    .PAD_TIMEOUT(PAD_TIMEOUT),
    .ERR_HOLD   (ERR_HOLD)
  ) input_i (
    .clk, .rst_n, .start, .exit, .rx_data, .rx_valid, .val_min, .val_max,
    .req_ready, .echo_done, .req_valid, .req_kind, .req_value, .err, .done,
    .wr(wr_if.master),
    .rd(rd_if.master)
  );

  matrix_store #(.MAX_ROWS(MAX_ROWS), .MAX_COLS(MAX_COLS), .NUM_SLOTS(NUM_SLOTS)) store_i (
    .clk, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_o, .wb_ack,
    .wr(wr_if.slave),
    .rd(rd_if.slave)
  );

  echo_sender echo_i (
    .clk, .rst_n, .req_valid, .req_kind, .req_value, .tx_ready,
    .req_ready, .done(echo_done), .tx_data, .tx_valid
  );

endmodule

// File: matrix_if.sv
// write and read interfaces between the entry controller and the matrix store
`timescale 1ns/1ps

interface matrix_wr_if import matrix_entry_pkg::*; #(
  parameter int MAX_ROWS  = 4,
  parameter int MAX_COLS  = 4,
  parameter int NUM_SLOTS = 4
) ();
  localparam int SLOT_W = idx_w(NUM_SLOTS);
  localparam int ROW_W  = idx_w(MAX_ROWS);
  localparam int COL_W  = idx_w(MAX_COLS);
  localparam int DIM_W  = dim_w(MAX_ROWS, MAX_COLS);

  // alloc claims the next slot, rows and cols travel with it
  logic             alloc;
  logic [DIM_W-1:0] rows;
  logic [DIM_W-1:0] cols;
  // single cell write into the last allocated slot
  logic             wr;
  logic [ROW_W-1:0] row;
  logic [COL_W-1:0] col;
  elem_t            data;
  logic [SLOT_W-1:0] last_slot;

  modport master (output alloc, rows, cols, wr, row, col, data, input last_slot);
  modport slave  (input alloc, rows, cols, wr, row, col, data, output last_slot);
endinterface

interface matrix_rd_if import matrix_entry_pkg::*; #(
  parameter int MAX_ROWS  = 4,
  parameter int MAX_COLS  = 4,
  parameter int NUM_SLOTS = 4
) ();
  localparam int SLOT_W = idx_w(NUM_SLOTS);
  localparam int ROW_W  = idx_w(MAX_ROWS);
  localparam int COL_W  = idx_w(MAX_COLS);

  // combinational read, data follows the address in the same cycle
  logic [SLOT_W-1:0] slot;
  logic [ROW_W-1:0]  row;
  logic [COL_W-1:0]  col;
  elem_t             data;

  modport master (output slot, row, col, input data);
  modport slave  (input slot, row, col, output data);
endinterface

// File: matrix_input.sv
// entry controller: parses dimensions and elements, pads on stall, flags errors, drives the echo
`timescale 1ns/1ps

module matrix_input import matrix_entry_pkg::*; #(
  parameter int MAX_ROWS    = 4,
  parameter int MAX_COLS    = 4,
  parameter int NUM_SLOTS   = 4,
  parameter int PAD_TIMEOUT = 1000,
  parameter int ERR_HOLD    = 200
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        start,
  input  logic        exit,
  input  logic [7:0]  rx_data,
  input  logic        rx_valid,
  input  elem_t       val_min,
  input  elem_t       val_max,
  input  logic        req_ready,
  input  logic        echo_done,
  output logic        req_valid,
  output echo_kind_t  req_kind,
  output logic [7:0]  req_value,
  output logic        err,
  output logic        done,
  matrix_wr_if.master wr,
  matrix_rd_if.master rd
);
  localparam int SLOT_W  = idx_w(NUM_SLOTS);
  localparam int ROW_W   = idx_w(MAX_ROWS);
  localparam int COL_W   = idx_w(MAX_COLS);
  localparam int DIM_W   = dim_w(MAX_ROWS, MAX_COLS);
  localparam int TMR_MAX = (PAD_TIMEOUT > ERR_HOLD) ? PAD_TIMEOUT : ERR_HOLD;
  localparam int TMR_W   = $clog2(TMR_MAX + 1);

  typedef enum logic [4:0] {
    S_IDLE,
    S_BANNER,
    S_BANNER_WAIT,
    S_ROWS,
    S_COLS,
    S_ALLOC,
    S_ELEM,
    S_WRITE,
    S_ADVANCE,
    S_ECHO_ID,
    S_ID_WAIT,
    S_ECHO_CELL,
    S_CELL_WAIT,
    S_ECHO_NL,
    S_NL_WAIT,
    S_ERROR,
    S_DONE
  } state_t;

  state_t state, next_state;

  logic [TMR_W-1:0]  timer;
  logic [DIM_W-1:0]  rows_q;
  logic [DIM_W-1:0]  cols_q;
  logic [ROW_W-1:0]  row_cnt;
  logic [COL_W-1:0]  col_cnt;
  logic [SLOT_W-1:0] echo_slot;
  logic              pad;
  elem_t             elem_q;
  elem_t             rx_elem;
  logic              rows_ok, cols_ok, elem_ok;
  logic              last_col, last_row, last_cell;
  logic              pad_due, err_due;
  logic              cnt_step, cnt_clear;

  assign rx_elem = rx_data;
  assign rows_ok = (rx_elem >= 1) && (rx_elem <= MAX_ROWS);
  assign cols_ok = (rx_elem >= 1) && (rx_elem <= MAX_COLS);
  assign elem_ok = (rx_elem >= val_min) && (rx_elem <= val_max);

  assign last_col  = (DIM_W'(col_cnt) == cols_q - DIM_W'(1));
  assign last_row  = (DIM_W'(row_cnt) == rows_q - DIM_W'(1));
  assign last_cell = last_col && last_row;

  assign pad_due = (timer == TMR_W'(PAD_TIMEOUT - 1));
  assign err_due = (timer == TMR_W'(ERR_HOLD - 1));

  always_comb begin
    next_state = state;
    case (state)
      S_IDLE:        if (start) next_state = S_BANNER;
      S_BANNER:      if (req_ready) next_state = S_BANNER_WAIT;
      S_BANNER_WAIT: if (echo_done) next_state = S_ROWS;
      S_ROWS: begin
        if (exit) next_state = S_DONE;
        else if (rx_valid) next_state = rows_ok ? S_COLS : S_ERROR;
      end
      S_COLS:        if (rx_valid) next_state = cols_ok ? S_ALLOC : S_ERROR;
      S_ALLOC:       next_state = S_ELEM;
      S_ELEM: begin
        // a byte in the same cycle as the timeout still counts
        if (rx_valid) next_state = elem_ok ? S_WRITE : S_ERROR;
        else if (pad_due) next_state = S_WRITE;
      end
      S_WRITE:       next_state = S_ADVANCE;
      S_ADVANCE: begin
        if (last_cell) next_state = S_ECHO_ID;
        else if (pad) next_state = S_WRITE;
        else next_state = S_ELEM;
      end
      S_ECHO_ID:     if (req_ready) next_state = S_ID_WAIT;
      S_ID_WAIT:     if (echo_done) next_state = S_ECHO_CELL;
      S_ECHO_CELL:   if (req_ready) next_state = S_CELL_WAIT;
      S_CELL_WAIT: begin
        if (echo_done) next_state = last_cell ? S_ECHO_NL : S_ECHO_CELL;
      end
      S_ECHO_NL:     if (req_ready) next_state = S_NL_WAIT;
      S_NL_WAIT:     if (echo_done) next_state = S_ROWS;
      S_ERROR:       if (err_due) next_state = S_ROWS;
      S_DONE:        if (!start) next_state = S_IDLE;
      default:       next_state = S_IDLE;
    endcase
  end

  // shared row/col walk, used for writes and again for the echo reads
  assign cnt_clear = (state == S_ALLOC) || (state == S_ADVANCE && last_cell);
  assign cnt_step  = (state == S_ADVANCE && !last_cell) ||
                     (state == S_CELL_WAIT && echo_done && !last_cell);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= S_IDLE;
      timer     <= '0;
      rows_q    <= '0;
      cols_q    <= '0;
      row_cnt   <= '0;
      col_cnt   <= '0;
      echo_slot <= '0;
      pad       <= 1'b0;
      wr.alloc  <= 1'b0;
      wr.wr     <= 1'b0;
      done      <= 1'b0;
    end else begin
      state    <= next_state;
      wr.alloc <= (state == S_ALLOC);
      wr.wr    <= (state == S_WRITE);
      done     <= (state == S_ROWS) && exit;

      // one timer, restarted on every state change
      if ((state == S_ELEM || state == S_ERROR) && next_state == state) begin
        timer <= timer + 1'b1;
      end else begin
        timer <= '0;
      end

      if (state == S_ROWS && rx_valid && rows_ok) rows_q <= DIM_W'(rx_data);
      if (state == S_COLS && rx_valid && cols_ok) cols_q <= DIM_W'(rx_data);

      if (state == S_ALLOC) begin
        pad <= 1'b0;
      end else if (state == S_ELEM && !rx_valid && pad_due) begin
        // stays set until the matrix is finished
        pad <= 1'b1;
      end

      if (state == S_ADVANCE && last_cell) echo_slot <= wr.last_slot;

      if (cnt_clear) begin
        row_cnt <= '0;
        col_cnt <= '0;
      end else if (cnt_step) begin
        if (last_col) begin
          col_cnt <= '0;
          row_cnt <= row_cnt + 1'b1;
        end else begin
          col_cnt <= col_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_ELEM && rx_valid) elem_q <= rx_elem;
  end

  assign wr.rows = rows_q;
  assign wr.cols = cols_q;
  assign wr.row  = row_cnt;
  assign wr.col  = col_cnt;
  assign wr.data = pad ? elem_t'(0) : elem_q;

  assign rd.slot = echo_slot;
  assign rd.row  = row_cnt;
  assign rd.col  = col_cnt;

  assign err = (state == S_ERROR);

  // request stays up while the state waits for req_ready
  always_comb begin
    req_valid = 1'b0;
    req_kind  = ECHO_NEWLINE;
    req_value = '0;
    case (state)
      S_BANNER: begin
        req_valid = 1'b1;
        req_kind  = ECHO_BANNER;
      end
      S_ECHO_ID: begin
        req_valid = 1'b1;
        req_kind  = ECHO_ID;
        req_value = 8'(echo_slot);
      end
      S_ECHO_CELL: begin
        req_valid = 1'b1;
        req_kind  = last_col ? ECHO_CELL_LAST : ECHO_CELL;
        req_value = rd.data;
      end
      S_ECHO_NL: begin
        req_valid = 1'b1;
        req_kind  = ECHO_NEWLINE;
      end
      default: begin
        req_valid = 1'b0;
      end
    endcase
  end

  // writes stay inside the dimensions claimed at alloc time
  a_wr_in_dims: assert property (@(posedge clk) disable iff (!rst_n)
    wr.wr |-> (DIM_W'(wr.row) < rows_q) && (DIM_W'(wr.col) < cols_q));

endmodule

// File: matrix_store.sv
// multi-slot matrix cell store with controller write/read ports and a wishbone read slave
`timescale 1ns/1ps

module matrix_store import matrix_entry_pkg::*; #(
  parameter int MAX_ROWS  = 4,
  parameter int MAX_COLS  = 4,
  parameter int NUM_SLOTS = 4,
  localparam int ADR_W    = 1 + idx_w(NUM_SLOTS) + idx_w(MAX_ROWS) + idx_w(MAX_COLS)
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             wb_cyc,
  input  logic             wb_stb,
  input  logic             wb_we,
  input  logic [ADR_W-1:0] wb_adr,
  output logic [7:0]       wb_dat_o,
  output logic             wb_ack,
  matrix_wr_if.slave       wr,
  matrix_rd_if.slave       rd
);
  localparam int SLOT_W = idx_w(NUM_SLOTS);
  localparam int ROW_W  = idx_w(MAX_ROWS);
  localparam int COL_W  = idx_w(MAX_COLS);
  localparam int DIM_W  = dim_w(MAX_ROWS, MAX_COLS);

  elem_t             cells [NUM_SLOTS][MAX_ROWS][MAX_COLS];
  logic [DIM_W-1:0]  slot_rows [NUM_SLOTS];
  logic [DIM_W-1:0]  slot_cols [NUM_SLOTS];
  logic [SLOT_W-1:0] next_slot;
  logic [SLOT_W-1:0] last_slot_q;
  logic              any_valid;

  logic [SLOT_W-1:0] cell_slot;
  logic [ROW_W-1:0]  cell_row;
  logic [COL_W-1:0]  cell_col;
  logic [ADR_W-2:0]  reg_off;
  logic [7:0]        rd_word;
  logic              wb_hit;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < NUM_SLOTS; s++) begin
        slot_rows[s] <= '0;
        slot_cols[s] <= '0;
        for (int r = 0; r < MAX_ROWS; r++) begin
          for (int c = 0; c < MAX_COLS; c++) begin
            cells[s][r][c] <= '0;
          end
        end
      end
      next_slot   <= '0;
      last_slot_q <= '0;
      any_valid   <= 1'b0;
    end else if (wr.alloc) begin
      // new slot starts out all zero
      for (int r = 0; r < MAX_ROWS; r++) begin
        for (int c = 0; c < MAX_COLS; c++) begin
          cells[next_slot][r][c] <= '0;
        end
      end
      slot_rows[next_slot] <= wr.rows;
      slot_cols[next_slot] <= wr.cols;
      last_slot_q <= next_slot;
      any_valid   <= 1'b1;
      if (next_slot == SLOT_W'(NUM_SLOTS - 1)) begin
        next_slot <= '0;
      end else begin
        next_slot <= next_slot + 1'b1;
      end
    end else if (wr.wr) begin
      cells[last_slot_q][wr.row][wr.col] <= wr.data;
    end
  end

  assign wr.last_slot = last_slot_q;
  assign rd.data      = cells[rd.slot][rd.row][rd.col];

  // cell address fields: slot, row, col from high to low
  assign cell_slot = wb_adr[ROW_W+COL_W +: SLOT_W];
  assign cell_row  = wb_adr[COL_W +: ROW_W];
  assign cell_col  = wb_adr[0 +: COL_W];
  assign reg_off   = wb_adr[ADR_W-2:0];

  always_comb begin
    rd_word = '0;
    if (wb_adr[ADR_W-1]) begin
      if (int'(cell_slot) < NUM_SLOTS && int'(cell_row) < MAX_ROWS &&
          int'(cell_col) < MAX_COLS) begin
        rd_word = cells[cell_slot][cell_row][cell_col];
      end
    end else if (reg_off == 0) begin
      rd_word = 8'(last_slot_q);
      rd_word[7] = any_valid;
    end else if (reg_off == 1) begin
      rd_word = {4'(slot_rows[last_slot_q]), 4'(slot_cols[last_slot_q])};
    end
  end

  // classic cycle, one ack per request
  assign wb_hit = wb_cyc && wb_stb && !wb_ack;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= wb_hit;
    end
  end

  always_ff @(posedge clk) begin
    if (wb_hit) wb_dat_o <= wb_we ? 8'h00 : rd_word;
  end

  a_ack_single: assert property (@(posedge clk) disable iff (!rst_n)
    wb_ack |=> !wb_ack);

endmodule

// File: run.sh
#!/bin/sh
# build with verilator, run, and pass only when the testbench prints the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module matrix_entry_tb \
  -f matrix_entry.f -o matrix_entry_sim || { echo "run.sh: build failed"; exit 1; }
out="$(./obj_dir/matrix_entry_sim)"
echo "$out"
echo "$out" | grep -qF '*** PASSED ***' && echo "run.sh: simulation passed" && exit 0 ||
  { echo "run.sh: simulation failed"; exit 1; }
